/* run_sim.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it.
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -f sim.f --top-module tb_rv32_decode_stage -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi
exit 0

/* rv32_dec_if.sv */
`timescale 1ns/100ps

interface exec_dec_if
    import rv32_decode_pkg::*;
();
    logic           hit;
    logic           rs1_read;
    logic           rs2_read;
    imm_sel_t       imm;
    alu_op_t        alu_op;
    logic           alu_sub_sra;
    alu_src1_t      alu_src1;
    alu_src2_t      alu_src2;
    branch_op_t     branch_op;
    branch_pc_src_t branch_pc_src;
    logic           rd_write;

    modport src (
        output hit, rs1_read, rs2_read, imm, alu_op, alu_sub_sra, alu_src1, alu_src2,
               branch_op, branch_pc_src, rd_write
    );

    modport dst (
        input hit, rs1_read, rs2_read, imm, alu_op, alu_sub_sra, alu_src1, alu_src2,
              branch_op, branch_pc_src, rd_write
    );
endinterface

interface sys_dec_if
    import rv32_decode_pkg::*;
();
    logic       hit;
    logic       rs1_read;
    imm_sel_t   imm;
    logic       mem_read;
    logic       mem_write;
    mem_width_t mem_width;
    logic       mem_zero_extend;
    logic       mem_fence;
    logic       csr_read;
    logic       csr_write;
    csr_op_t    csr_write_op;
    csr_src_t   csr_src;
    logic       rd_write;

    modport src (
        output hit, rs1_read, imm, mem_read, mem_write, mem_width, mem_zero_extend,
               mem_fence, csr_read, csr_write, csr_write_op, csr_src, rd_write
    );

    modport dst (
        input hit, rs1_read, imm, mem_read, mem_write, mem_width, mem_zero_extend,
              mem_fence, csr_read, csr_write, csr_write_op, csr_src, rd_write
    );
endinterface

/* rv32_decode_merge.sv */
`timescale 1ns/100ps

module rv32_decode_merge
    import rv32_decode_pkg::*;
#(
    parameter int BUF_DEPTH    = 4, // Power of two, at least 2.
    parameter int CTRL_CREDITS = 2
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       instr_valid,
    exec_dec_if.dst    exec_dec,
    sys_dec_if.dst     sys_dec,
    input  logic       ctrl_credit,
    output logic       ctrl_valid,
    output ctrl_word_t ctrl,
    output logic       ctrl_illegal,
    output logic       instr_credit
);
    localparam int PTR_W  = $clog2(BUF_DEPTH);
    localparam int CNT_W  = $clog2(BUF_DEPTH + 1);
    localparam int CRED_W = $clog2(CTRL_CREDITS + 2); // Headroom to catch an overflow.

    logic              legal;
    logic              pop;
    ctrl_word_t        merged;
    ctrl_word_t        ctrl_mem [BUF_DEPTH];
    logic              illegal_mem [BUF_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic [CRED_W-1:0] credits;

    assign legal = exec_dec.hit | sys_dec.hit;

    always_comb begin
        merged = '0; // Illegal words leave every enable low.
        if (legal) begin
            merged.rs1_read        = exec_dec.rs1_read | sys_dec.rs1_read;
            merged.rs2_read        = exec_dec.rs2_read;
            merged.imm             = exec_dec.hit ? exec_dec.imm : sys_dec.imm;
            merged.alu_op          = exec_dec.alu_op;
            merged.alu_sub_sra     = exec_dec.alu_sub_sra;
            merged.alu_src1        = exec_dec.alu_src1;
            merged.alu_src2        = exec_dec.alu_src2;
            merged.mem_read        = sys_dec.mem_read;
            merged.mem_write       = sys_dec.mem_write;
            merged.mem_width       = sys_dec.mem_width;
            merged.mem_zero_extend = sys_dec.mem_zero_extend;
            merged.mem_fence       = sys_dec.mem_fence;
            merged.csr_read        = sys_dec.csr_read;
            merged.csr_write       = sys_dec.csr_write;
            merged.csr_write_op    = sys_dec.csr_write_op;
            merged.csr_src         = sys_dec.csr_src;
            merged.branch_op       = exec_dec.branch_op;
            merged.branch_pc_src   = exec_dec.branch_pc_src;
            merged.rd_write        = exec_dec.rd_write | sys_dec.rd_write;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            ctrl_mem[wr_ptr]    <= merged;
            illegal_mem[wr_ptr] <= !legal;
        end
    end

    assign pop          = (count != '0) && (credits != '0);
    assign ctrl_valid   = pop;
    assign ctrl         = ctrl_mem[rd_ptr];
    assign ctrl_illegal = illegal_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            credits      <= CRED_W'(CTRL_CREDITS);
            instr_credit <= 1'b0;
        end else begin
            if (instr_valid) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count        <= count + CNT_W'(instr_valid) - CNT_W'(pop);
            credits      <= credits + CRED_W'(ctrl_credit) - CRED_W'(pop);
            instr_credit <= pop; // Returns the freed slot upstream.
        end
    end

    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> !(exec_dec.hit && sys_dec.hit))
        else $error("execute and system decoders both claim the word");

    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n)
        instr_valid |-> (count != CNT_W'(BUF_DEPTH)))
        else $error("instruction pushed into a full buffer");

    a_credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= CRED_W'(CTRL_CREDITS))
        else $error("downstream returned more credits than it was given");

endmodule

/* rv32_decode_pkg.sv */
package rv32_decode_pkg;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [6:0]  opcode_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U,
        IMM_J,
        IMM_SHAMT,
        IMM_ZIMM
    } imm_sel_t;

    // Ordered so that funct3 casts straight onto the ALU operation.
    typedef enum logic [2:0] {
        ALU_ADD_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    typedef enum logic [1:0] {SRC1_ZERO, SRC1_REG, SRC1_PC} alu_src1_t;
    typedef enum logic [1:0] {SRC2_ZERO, SRC2_REG, SRC2_IMM, SRC2_FOUR} alu_src2_t;
    typedef enum logic [1:0] {WIDTH_BYTE, WIDTH_HALF, WIDTH_WORD} mem_width_t;

    // Matches funct3[1:0] of the CSR instructions.
    typedef enum logic [1:0] {CSR_OP_NONE, CSR_OP_RW, CSR_OP_RS, CSR_OP_RC} csr_op_t;
    typedef enum logic {CSR_SRC_REG, CSR_SRC_IMM} csr_src_t;

    typedef enum logic [1:0] {BR_NEVER, BR_ZERO, BR_NON_ZERO, BR_ALWAYS} branch_op_t;
    typedef enum logic {PC_SRC_IMM, PC_SRC_REG} branch_pc_src_t;

    typedef struct packed {
        logic           rs1_read;
        logic           rs2_read;
        imm_sel_t       imm;
        alu_op_t        alu_op;
        logic           alu_sub_sra;
        alu_src1_t      alu_src1;
        alu_src2_t      alu_src2;
        logic           mem_read;
        logic           mem_write;
        mem_width_t     mem_width;
        logic           mem_zero_extend;
        logic           mem_fence;
        logic           csr_read;
        logic           csr_write;
        csr_op_t        csr_write_op;
        csr_src_t       csr_src;
        branch_op_t     branch_op;
        branch_pc_src_t branch_pc_src;
        logic           rd_write;
    } ctrl_word_t;

    localparam opcode_t OPC_LUI      = 7'b0110111;
    localparam opcode_t OPC_AUIPC    = 7'b0010111;
    localparam opcode_t OPC_JAL      = 7'b1101111;
    localparam opcode_t OPC_JALR     = 7'b1100111;
    localparam opcode_t OPC_BRANCH   = 7'b1100011;
    localparam opcode_t OPC_LOAD     = 7'b0000011;
    localparam opcode_t OPC_STORE    = 7'b0100011;
    localparam opcode_t OPC_OP_IMM   = 7'b0010011;
    localparam opcode_t OPC_OP       = 7'b0110011;
    localparam opcode_t OPC_MISC_MEM = 7'b0001111;
    localparam opcode_t OPC_SYSTEM   = 7'b1110011;

endpackage

/* rv32_decode_stage.sv */
`timescale 1ns/100ps

module rv32_decode_stage
    import rv32_decode_pkg::*;
#(
    parameter int BUF_DEPTH    = 4,
    parameter int CTRL_CREDITS = 2
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           instr_valid,
    input  instr_t         instr,
    input  logic           ctrl_credit,
    output logic           instr_credit,
    output logic           ctrl_valid,
    output logic           ctrl_illegal,
    output logic           ctrl_rs1_read,
    output logic           ctrl_rs2_read,
    output imm_sel_t       ctrl_imm,
    output alu_op_t        ctrl_alu_op,
    output logic           ctrl_alu_sub_sra,
    output alu_src1_t      ctrl_alu_src1,
    output alu_src2_t      ctrl_alu_src2,
    output logic           ctrl_mem_read,
    output logic           ctrl_mem_write,
    output mem_width_t     ctrl_mem_width,
    output logic           ctrl_mem_zero_extend,
    output logic           ctrl_mem_fence,
    output logic           ctrl_csr_read,
    output logic           ctrl_csr_write,
    output csr_op_t        ctrl_csr_write_op,
    output csr_src_t       ctrl_csr_src,
    output branch_op_t     ctrl_branch_op,
    output branch_pc_src_t ctrl_branch_pc_src,
    output logic           ctrl_rd_write
);
    ctrl_word_t ctrl;

    exec_dec_if exec_dec ();
    sys_dec_if  sys_dec ();

    rv32_exec_decoder u_exec_decoder (
        .instr (instr),
        .dec   (exec_dec.src)
    );

    rv32_sys_decoder u_sys_decoder (
        .instr (instr),
        .dec   (sys_dec.src)
    );

    rv32_decode_merge #(
        .BUF_DEPTH    (BUF_DEPTH),
        .CTRL_CREDITS (CTRL_CREDITS)
    ) u_merge (
        .clk          (clk),
        .rst_n        (rst_n),
        .instr_valid  (instr_valid),
        .exec_dec     (exec_dec.dst),
        .sys_dec      (sys_dec.dst),
        .ctrl_credit  (ctrl_credit),
        .ctrl_valid   (ctrl_valid),
        .ctrl         (ctrl),
        .ctrl_illegal (ctrl_illegal),
        .instr_credit (instr_credit)
    );

    assign ctrl_rs1_read        = ctrl.rs1_read;
    assign ctrl_rs2_read        = ctrl.rs2_read;
    assign ctrl_imm             = ctrl.imm;
    assign ctrl_alu_op          = ctrl.alu_op;
    assign ctrl_alu_sub_sra     = ctrl.alu_sub_sra;
    assign ctrl_alu_src1        = ctrl.alu_src1;
    assign ctrl_alu_src2        = ctrl.alu_src2;
    assign ctrl_mem_read        = ctrl.mem_read;
    assign ctrl_mem_write       = ctrl.mem_write;
    assign ctrl_mem_width       = ctrl.mem_width;
    assign ctrl_mem_zero_extend = ctrl.mem_zero_extend;
    assign ctrl_mem_fence       = ctrl.mem_fence;
    assign ctrl_csr_read        = ctrl.csr_read;
    assign ctrl_csr_write       = ctrl.csr_write;
    assign ctrl_csr_write_op    = ctrl.csr_write_op;
    assign ctrl_csr_src         = ctrl.csr_src;
    assign ctrl_branch_op       = ctrl.branch_op;
    assign ctrl_branch_pc_src   = ctrl.branch_pc_src;
    assign ctrl_rd_write        = ctrl.rd_write;

endmodule

/* rv32_exec_decoder.sv */
`timescale 1ns/100ps

module rv32_exec_decoder
    import rv32_decode_pkg::*;
(
    input instr_t   instr,
    exec_dec_if.src dec
);
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000; // SUB and SRA(I).

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        dec.hit           = 1'b0;
        dec.rs1_read      = 1'b0;
        dec.rs2_read      = 1'b0;
        dec.imm           = IMM_NONE;
        dec.alu_op        = ALU_ADD_SUB;
        dec.alu_sub_sra   = 1'b0;
        dec.alu_src1      = SRC1_ZERO;
        dec.alu_src2      = SRC2_ZERO;
        dec.branch_op     = BR_NEVER;
        dec.branch_pc_src = PC_SRC_IMM;
        dec.rd_write      = 1'b0;

        case (opcode)
            OPC_LUI, OPC_AUIPC: begin
                dec.hit      = 1'b1;
                dec.imm      = IMM_U;
                dec.alu_src1 = (opcode == OPC_AUIPC) ? SRC1_PC : SRC1_ZERO;
                dec.alu_src2 = SRC2_IMM;
                dec.rd_write = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                dec.hit       = (opcode == OPC_JAL) || (funct3 == 3'b000);
                dec.rs1_read  = (opcode == OPC_JALR);
                dec.imm       = (opcode == OPC_JAL) ? IMM_J : IMM_I;
                dec.alu_src1  = SRC1_PC; // Link value is pc + 4.
                dec.alu_src2  = SRC2_FOUR;
                dec.branch_op = BR_ALWAYS;
                dec.branch_pc_src = (opcode == OPC_JAL) ? PC_SRC_IMM : PC_SRC_REG;
                dec.rd_write  = 1'b1;
            end
            OPC_BRANCH: begin
                dec.hit         = (funct3[2:1] != 2'b01);
                dec.rs1_read    = 1'b1;
                dec.rs2_read    = 1'b1;
                dec.imm         = IMM_B;
                dec.alu_sub_sra = 1'b1;
                dec.alu_src1    = SRC1_REG;
                dec.alu_src2    = SRC2_REG;
                case (funct3[2:1])
                    2'b00:   dec.alu_op = ALU_ADD_SUB;
                    2'b10:   dec.alu_op = ALU_SLT;
                    default: dec.alu_op = ALU_SLTU;
                endcase
                // BNE, BLT and BLTU take the branch on a nonzero ALU result.
                dec.branch_op = (funct3[0] ^ funct3[2]) ? BR_NON_ZERO : BR_ZERO;
            end
            OPC_LOAD, OPC_STORE: begin
                dec.rs1_read = 1'b1;
                dec.alu_src1 = SRC1_REG;
                dec.alu_src2 = SRC2_IMM;
                if (opcode == OPC_LOAD) begin
                    dec.hit      = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
                    dec.imm      = IMM_I;
                    dec.rd_write = 1'b1;
                end else begin
                    dec.hit      = funct3 inside {3'b000, 3'b001, 3'b010};
                    dec.rs2_read = 1'b1;
                    dec.imm      = IMM_S;
                end
            end
            OPC_OP_IMM: begin
                dec.hit      = 1'b1;
                dec.rs1_read = 1'b1;
                dec.imm      = IMM_I;
                dec.alu_op   = alu_op_t'(funct3);
                dec.alu_src1 = SRC1_REG;
                dec.alu_src2 = SRC2_IMM;
                dec.rd_write = 1'b1;
                case (funct3)
                    3'b001: begin
                        dec.hit = (funct7 == 7'b0);
                        dec.imm = IMM_SHAMT;
                    end
                    3'b101: begin
                        dec.hit         = (funct7 == 7'b0) || (funct7 == FUNCT7_ALT);
                        dec.imm         = IMM_SHAMT;
                        dec.alu_sub_sra = funct7[5];
                    end
                    3'b010, 3'b011: dec.alu_sub_sra = 1'b1;
                    default: ;
                endcase
            end
            OPC_OP: begin
                dec.hit = (funct7 == 7'b0) ||
                          ((funct7 == FUNCT7_ALT) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                dec.rs1_read    = 1'b1;
                dec.rs2_read    = 1'b1;
                dec.alu_op      = alu_op_t'(funct3);
                dec.alu_sub_sra = funct7[5] || (funct3[2:1] == 2'b01);
                dec.alu_src1    = SRC1_REG;
                dec.alu_src2    = SRC2_REG;
                dec.rd_write    = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* rv32_sys_decoder.sv */
`timescale 1ns/100ps

module rv32_sys_decoder
    import rv32_decode_pkg::*;
(
    input instr_t  instr,
    sys_dec_if.src dec
);
    opcode_t    opcode;
    logic [2:0] funct3;
    reg_idx_t   rs1;
    reg_idx_t   rd;
    mem_width_t width;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rd     = instr[11:7];

    // Reserved widths are rejected by the execute decoder.
    assign width = (funct3[1:0] == 2'b00) ? WIDTH_BYTE :
                   (funct3[1:0] == 2'b01) ? WIDTH_HALF : WIDTH_WORD;

    always_comb begin
        dec.hit             = 1'b0;
        dec.rs1_read        = 1'b0;
        dec.imm             = IMM_NONE;
        dec.mem_read        = 1'b0;
        dec.mem_write       = 1'b0;
        dec.mem_width       = WIDTH_BYTE;
        dec.mem_zero_extend = 1'b0;
        dec.mem_fence       = 1'b0;
        dec.csr_read        = 1'b0;
        dec.csr_write       = 1'b0;
        dec.csr_write_op    = CSR_OP_NONE;
        dec.csr_src         = CSR_SRC_REG;
        dec.rd_write        = 1'b0;

        case (opcode)
            OPC_LOAD: begin
                dec.mem_read        = 1'b1;
                dec.mem_width       = width;
                dec.mem_zero_extend = funct3[2]; // LBU and LHU.
            end
            OPC_STORE: begin
                dec.mem_write = 1'b1;
                dec.mem_width = width;
            end
            OPC_MISC_MEM: begin
                dec.hit       = (funct3[2:1] == 2'b00);
                dec.mem_fence = (funct3 == 3'b001); // FENCE.I only.
            end
            OPC_SYSTEM: begin
                if (funct3[1:0] != 2'b00) begin
                    dec.hit          = 1'b1;
                    dec.rs1_read     = !funct3[2];
                    dec.imm          = funct3[2] ? IMM_ZIMM : IMM_NONE;
                    dec.csr_write_op = csr_op_t'(funct3[1:0]);
                    dec.csr_src      = funct3[2] ? CSR_SRC_IMM : CSR_SRC_REG;
                    if (funct3[1:0] == 2'b01) begin
                        dec.csr_write = 1'b1;
                        dec.csr_read  = |rd; // No read side effect for rd = x0.
                        dec.rd_write  = |rd;
                    end else begin
                        dec.csr_read  = 1'b1;
                        dec.rd_write  = 1'b1;
                        dec.csr_write = |rs1;
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

/* sim.f */
rv32_decode_pkg.sv
rv32_dec_if.sv
rv32_exec_decoder.sv
rv32_sys_decoder.sv
rv32_decode_merge.sv
rv32_decode_stage.sv
tb_rv32_decode_stage.sv

/* tb_rv32_decode_stage.sv */
`timescale 1ns/100ps

module tb_rv32_decode_stage
    import rv32_decode_pkg::*;
();
    localparam int BUF_DEPTH    = 4;
    localparam int CTRL_CREDITS = 2;
    localparam int ENTRY_W      = $bits(ctrl_word_t) + 1;

    logic           clk = 1'b0;
    logic           rst_n;
    logic           instr_valid;
    instr_t         instr;
    logic           ctrl_credit;
    logic           instr_credit;
    logic           ctrl_valid;
    logic           ctrl_illegal;
    logic           ctrl_rs1_read;
    logic           ctrl_rs2_read;
    imm_sel_t       ctrl_imm;
    alu_op_t        ctrl_alu_op;
    logic           ctrl_alu_sub_sra;
    alu_src1_t      ctrl_alu_src1;
    alu_src2_t      ctrl_alu_src2;
    logic           ctrl_mem_read;
    logic           ctrl_mem_write;
    mem_width_t     ctrl_mem_width;
    logic           ctrl_mem_zero_extend;
    logic           ctrl_mem_fence;
    logic           ctrl_csr_read;
    logic           ctrl_csr_write;
    csr_op_t        ctrl_csr_write_op;
    csr_src_t       ctrl_csr_src;
    branch_op_t     ctrl_branch_op;
    branch_pc_src_t ctrl_branch_pc_src;
    logic           ctrl_rd_write;

    int                 seed = 88958;
    int                 sent_total = 0;
    int                 credit_pulses = 0;
    int                 xfers = 0;
    int                 granted = 0;
    int                 cycles = 0;
    logic               credit_en = 1'b0;
    logic [ENTRY_W-1:0] exp_mem [512];
    logic [8:0]         exp_wr = '0;
    logic [8:0]         exp_rd = '0;
    logic [ENTRY_W-1:0] exp_head;
    ctrl_word_t         got_ctrl;

    rv32_decode_stage #(
        .BUF_DEPTH    (BUF_DEPTH),
        .CTRL_CREDITS (CTRL_CREDITS)
    ) uut (
        .clk (clk), .rst_n (rst_n), .instr_valid (instr_valid), .instr (instr),
        .ctrl_credit (ctrl_credit), .instr_credit (instr_credit),
        .ctrl_valid (ctrl_valid), .ctrl_illegal (ctrl_illegal),
        .ctrl_rs1_read (ctrl_rs1_read), .ctrl_rs2_read (ctrl_rs2_read),
        .ctrl_imm (ctrl_imm), .ctrl_alu_op (ctrl_alu_op),
        .ctrl_alu_sub_sra (ctrl_alu_sub_sra), .ctrl_alu_src1 (ctrl_alu_src1),
        .ctrl_alu_src2 (ctrl_alu_src2), .ctrl_mem_read (ctrl_mem_read),
        .ctrl_mem_write (ctrl_mem_write), .ctrl_mem_width (ctrl_mem_width),
        .ctrl_mem_zero_extend (ctrl_mem_zero_extend), .ctrl_mem_fence (ctrl_mem_fence),
        .ctrl_csr_read (ctrl_csr_read), .ctrl_csr_write (ctrl_csr_write),
        .ctrl_csr_write_op (ctrl_csr_write_op), .ctrl_csr_src (ctrl_csr_src),
        .ctrl_branch_op (ctrl_branch_op), .ctrl_branch_pc_src (ctrl_branch_pc_src),
        .ctrl_rd_write (ctrl_rd_write)
    );

    always #2 clk = ~clk;

    assign got_ctrl = {ctrl_rs1_read, ctrl_rs2_read, ctrl_imm, ctrl_alu_op, ctrl_alu_sub_sra,
                       ctrl_alu_src1, ctrl_alu_src2, ctrl_mem_read, ctrl_mem_write,
                       ctrl_mem_width, ctrl_mem_zero_extend, ctrl_mem_fence, ctrl_csr_read,
                       ctrl_csr_write, ctrl_csr_write_op, ctrl_csr_src, ctrl_branch_op,
                       ctrl_branch_pc_src, ctrl_rd_write};
    assign exp_head = exp_mem[exp_rd];

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic alu_op_t alu_of(logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_ADD_SUB;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SRL_SRA;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Returns {illegal, control word} for one instruction word.
    function automatic logic [ENTRY_W-1:0] ref_decode(instr_t w);
        ctrl_word_t c;
        logic       ok;
        logic [2:0] f3;
        logic [6:0] f7;
        c  = '0;
        ok = 1'b0;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: begin
                ok         = 1'b1;
                c.imm      = IMM_U;
                c.alu_src1 = (w[6:0] == OPC_LUI) ? SRC1_ZERO : SRC1_PC;
                c.alu_src2 = SRC2_IMM;
                c.rd_write = 1'b1;
            end
            OPC_JAL, OPC_JALR: begin
                ok          = 1'b1;
                c.imm       = IMM_J;
                c.alu_src1  = SRC1_PC;
                c.alu_src2  = SRC2_FOUR;
                c.branch_op = BR_ALWAYS;
                c.rd_write  = 1'b1;
                if (w[6:0] == OPC_JALR) begin
                    ok              = (f3 == 3'd0);
                    c.rs1_read      = 1'b1;
                    c.imm           = IMM_I;
                    c.branch_pc_src = PC_SRC_REG;
                end
            end
            OPC_BRANCH: begin
                ok = 1'b1;
                case (f3)
                    3'd0, 3'd1: c.alu_op = ALU_ADD_SUB;
                    3'd4, 3'd5: c.alu_op = ALU_SLT;
                    3'd6, 3'd7: c.alu_op = ALU_SLTU;
                    default:    ok = 1'b0;
                endcase
                c.branch_op   = (f3 == 3'd1 || f3 == 3'd4 || f3 == 3'd6) ? BR_NON_ZERO : BR_ZERO;
                c.rs1_read    = 1'b1;
                c.rs2_read    = 1'b1;
                c.imm         = IMM_B;
                c.alu_sub_sra = 1'b1;
                c.alu_src1    = SRC1_REG;
                c.alu_src2    = SRC2_REG;
            end
            OPC_LOAD, OPC_STORE: begin
                c.rs1_read = 1'b1;
                c.alu_src1 = SRC1_REG;
                c.alu_src2 = SRC2_IMM;
                case (f3)
                    3'd0, 3'd4: c.mem_width = WIDTH_BYTE;
                    3'd1, 3'd5: c.mem_width = WIDTH_HALF;
                    default:    c.mem_width = WIDTH_WORD;
                endcase
                if (w[6:0] == OPC_LOAD) begin
                    ok                = (f3 <= 3'd2) || (f3 == 3'd4) || (f3 == 3'd5);
                    c.imm             = IMM_I;
                    c.rd_write        = 1'b1;
                    c.mem_read        = 1'b1;
                    c.mem_zero_extend = (f3 == 3'd4) || (f3 == 3'd5);
                end else begin
                    ok          = (f3 <= 3'd2);
                    c.rs2_read  = 1'b1;
                    c.imm       = IMM_S;
                    c.mem_write = 1'b1;
                end
            end
            OPC_OP_IMM: begin
                ok            = 1'b1;
                c.rs1_read    = 1'b1;
                c.imm         = (f3 == 3'd1 || f3 == 3'd5) ? IMM_SHAMT : IMM_I;
                c.alu_op      = alu_of(f3);
                c.alu_src1    = SRC1_REG;
                c.alu_src2    = SRC2_IMM;
                c.rd_write    = 1'b1;
                c.alu_sub_sra = (f3 == 3'd2) || (f3 == 3'd3) ||
                                (f3 == 3'd5 && f7 == 7'h20);
                if (f3 == 3'd1) ok = (f7 == 7'h00);
                if (f3 == 3'd5) ok = (f7 == 7'h00) || (f7 == 7'h20);
            end
            OPC_OP: begin
                ok = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                c.rs1_read    = 1'b1;
                c.rs2_read    = 1'b1;
                c.alu_op      = alu_of(f3);
                c.alu_sub_sra = (f7 == 7'h20) || (f3 == 3'd2) || (f3 == 3'd3);
                c.alu_src1    = SRC1_REG;
                c.alu_src2    = SRC2_REG;
                c.rd_write    = 1'b1;
            end
            OPC_MISC_MEM: begin
                ok          = (f3 == 3'd0) || (f3 == 3'd1);
                c.mem_fence = (f3 == 3'd1);
            end
            OPC_SYSTEM: begin
                ok = (f3 != 3'd0) && (f3 != 3'd4);
                case (f3)
                    3'd1, 3'd5: c.csr_write_op = CSR_OP_RW;
                    3'd2, 3'd6: c.csr_write_op = CSR_OP_RS;
                    default:    c.csr_write_op = CSR_OP_RC;
                endcase
                if (f3 >= 3'd5) begin
                    c.imm     = IMM_ZIMM;
                    c.csr_src = CSR_SRC_IMM;
                end else begin
                    c.rs1_read = 1'b1;
                end
                if (c.csr_write_op == CSR_OP_RW) begin
                    c.csr_write = 1'b1;
                    c.csr_read  = (w[11:7] != 5'd0);
                    c.rd_write  = (w[11:7] != 5'd0);
                end else begin
                    c.csr_read  = 1'b1;
                    c.rd_write  = 1'b1;
                    c.csr_write = (w[19:15] != 5'd0);
                end
            end
            default: ok = 1'b0;
        endcase
        if (!ok) c = '0;
        return {!ok, c};
    endfunction

    task automatic send_instr(instr_t w);
        while (BUF_DEPTH + credit_pulses - sent_total <= 0) @(negedge clk); // Wait for a credit.
        instr_valid     = 1'b1;
        instr           = w;
        exp_mem[exp_wr] = ref_decode(w);
        exp_wr          = exp_wr + 9'd1;
        sent_total++;
        @(negedge clk);
        instr_valid = 1'b0;
    endtask

    task automatic send_fields(opcode_t op, logic [2:0] f3);
        instr_t w;
        w        = $random(seed);
        w[6:0]   = op;
        w[14:12] = f3;
        send_instr(w);
    endtask

    task automatic wait_drained();
        while (exp_rd != exp_wr) @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            if (ctrl_valid) begin
                exp_rd <= exp_rd + 9'd1;
                xfers  <= xfers + 1;
            end
            if (instr_credit) credit_pulses <= credit_pulses + 1;
            if (ctrl_credit) granted <= granted + 1;
        end
    end

    // Downstream hands each spent credit back one cycle later while enabled.
    always @(negedge clk) begin
        ctrl_credit <= credit_en && rst_n && (xfers > granted);
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > 20 * sent_total + 200) abort_run("Timeout: the DUT stopped producing output.");
    end

    a_ctrl: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_valid |-> got_ctrl == exp_head[ENTRY_W-2:0])
        else abort_run($sformatf("MISMATCH at %0t: ctrl got %h expected %h", $time,
                                 $sampled(got_ctrl), $sampled(exp_head[ENTRY_W-2:0])));
    a_illegal: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_valid |-> ctrl_illegal == exp_head[ENTRY_W-1])
        else abort_run($sformatf("MISMATCH at %0t: ctrl_illegal got %b expected %b", $time,
                                 $sampled(ctrl_illegal), $sampled(exp_head[ENTRY_W-1])));
    a_no_extra: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_valid |-> exp_rd != exp_wr)
        else abort_run("Output appeared with no instruction waiting for it.");
    a_idle: assert property (@(posedge clk) disable iff (!rst_n)
        sent_total == 0 |-> !ctrl_valid && !instr_credit)
        else abort_run("Output or credit seen before any instruction was sent.");
    a_dn_credit: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_valid |-> CTRL_CREDITS + granted - xfers > 0)
        else abort_run("Transfer made without a downstream credit.");
    a_credit_back: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl_valid |=> instr_credit)
        else abort_run($sformatf("MISMATCH at %0t: instr_credit got 0 expected 1", $time));
    a_no_credit: assert property (@(posedge clk) disable iff (!rst_n)
        !ctrl_valid |=> !instr_credit)
        else abort_run($sformatf("MISMATCH at %0t: instr_credit got 1 expected 0", $time));

    initial begin
        instr_t w;
        int     base;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        ctrl_credit = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        repeat (10) @(negedge clk);
        credit_en = 1'b1;

        for (int i = 0; i < 200; i++) begin
            w          = $random(seed);
            w[6:0]     = w[31] ? OPC_OP : OPC_OP_IMM;
            w[31:25]   = w[30] ? 7'h20 : 7'h00; // SUB and SRA variants.
            send_instr(w);
        end

        for (int f = 0; f < 8; f++) begin
            send_fields(OPC_LOAD, 3'(f));
            send_fields(OPC_STORE, 3'(f));
            send_fields(OPC_BRANCH, 3'(f));
        end
        send_fields(OPC_JAL, 3'd0);
        send_fields(OPC_JALR, 3'd0);
        send_fields(OPC_LUI, 3'd2);
        send_fields(OPC_AUIPC, 3'd7);
        send_instr(32'h0ff0000f);
        send_instr(32'h0000100f);

        for (int f = 1; f < 8; f++) begin
            for (int k = 0; k < 4; k++) begin
                w          = $random(seed);
                w[6:0]     = OPC_SYSTEM;
                w[14:12]   = 3'(f);
                w[11:7]    = k[0] ? (w[11:7] | 5'd1) : 5'd0;
                w[19:15]   = k[1] ? (w[19:15] | 5'd1) : 5'd0;
                send_instr(w);
            end
        end

        send_instr(32'h00000073);
        send_instr(32'h00100073);
        send_instr(32'h30200073);
        send_instr(32'h10500073);
        send_instr(32'h02208033); // MUL has a reserved funct7 in RV32I.
        send_instr(32'h40109093);
        for (int i = 0; i < 40; i++) begin
            w = $random(seed);
            send_instr(w);
        end

        wait_drained();
        while (granted != xfers) @(negedge clk);
        credit_en = 1'b0;
        @(negedge clk);
        base = xfers;
        for (int i = 0; i < BUF_DEPTH + CTRL_CREDITS; i++) begin
            send_fields(OPC_OP_IMM, 3'(i));
        end
        repeat (30) @(negedge clk);
        if (xfers - base != CTRL_CREDITS) abort_run("Transfer count under back-pressure is wrong.");
        credit_en = 1'b1;
        wait_drained();
        repeat (4) @(negedge clk);

        if (credit_pulses != xfers || xfers != sent_total) begin
            abort_run("Credit pulses, transfers and sent instructions do not agree.");
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
